/* bench/tb_copro.sv */
`timescale 1ns/1ps
`default_nettype none

`include "copro_params.svh"

module tb_copro
    import copro_pkg::*;
();

    localparam int LED_ITERS    = 8;
    localparam int MEM_POOL     = 16;
    localparam int MEM_WRITES   = 48;
    localparam int MEM_READS    = 64;
    localparam int EXEC_CMDS    = 27;
    localparam int CHAIN_ROUNDS = 3;
    localparam int CHAIN_LEN    = 5;
    localparam int COMBO_ROUNDS = 4;
    localparam int MIX_READS    = 40;
    localparam int CMD_OPS      = 11;  // nine field writes plus launch and result read
    localparam int TOTAL_OPS    = 3 * LED_ITERS + MEM_POOL + MEM_WRITES + MEM_READS
                                + CMD_OPS * (`COPRO_RF_DEPTH + EXEC_CMDS)
                                + CHAIN_ROUNDS * (CMD_OPS + CHAIN_LEN)
                                + COMBO_ROUNDS * 2 * CMD_OPS + MIX_READS;
    localparam int CYCLE_LIMIT  = 20 * TOTAL_OPS;

    // no self-inverse or idempotent op so a stale operand changes the final result
    localparam alu_op_e CHAIN_OPS [CHAIN_ROUNDS] = '{ALU_ADD, ALU_SUB, ALU_MULADD};

    typedef struct packed {
        bus_addr_t   addr;
        word_t       data;
        logic [31:0] due;  // cycle the response must show up in
    } exp_rd_t;

    logic      clk_gen;
    logic      rst_n_i;
    bus_req_t  bus_req;
    bus_resp_t bus_resp;
    word_t     sw;
    word_t     led;

    int        seed = 56;
    int        cyc = 0;
    int        errors = 0;
    int        checks = 0;
    int        last_due = 0;
    int        result_ready = 0;

    exp_rd_t   exp_q [$];
    word_t     mem_model [int];
    word_t     rf_model [`COPRO_RF_DEPTH];
    word_t     led_model;
    word_t     result_model;
    cmd_t      staged;
    int        pool [MEM_POOL];

    copro_top copro_top_inst (
        .clk_gen    (clk_gen),
        .rst_n_i    (rst_n_i),
        .bus_req_i  (bus_req),
        .bus_resp_o (bus_resp),
        .sw_i       (sw),
        .led_o      (led)
    );

    initial
    begin
        clk_gen = 1'b0;
        forever #50 clk_gen = ~clk_gen;
    end

    always @(posedge clk_gen)
        cyc <= cyc + 1;

    initial
    begin
        wait (cyc >= CYCLE_LIMIT);
        $display("timeout: run stopped after %0d cycles", cyc);
        $display("Finished with errors");
        $finish;
    end

    function automatic word_t rand_word();
        return $random(seed);
    endfunction

    function automatic logic in_mem_window(bus_addr_t addr);
        return (addr >= `COPRO_MEM_BASE) && (addr < `COPRO_MEM_BASE + `COPRO_MEM_WORDS * 4);
    endfunction

    function automatic int word_index(bus_addr_t addr);
        return int'((addr - `COPRO_MEM_BASE) >> 2);
    endfunction

    function automatic bus_addr_t pool_addr();
        word_t w;
        w = rand_word();
        return `COPRO_MEM_BASE + bus_addr_t'(pool[w % MEM_POOL] * 4);
    endfunction

    // opcode rules with the shift amount taken from the low 5 bits of b
    function automatic word_t expected_alu(alu_op_e op, word_t a, word_t b, word_t c);
        case (op)
            ALU_ADD:    return a + b;
            ALU_SUB:    return a - b;
            ALU_AND:    return a & b;
            ALU_OR:     return a | b;
            ALU_XOR:    return a ^ b;
            ALU_SLL:    return a << b[4:0];
            ALU_SRL:    return a >> b[4:0];
            ALU_MUL:    return a * b;
            ALU_MULADD: return a * b + c;
            default:    return '0;
        endcase
    endfunction

    function automatic cmd_t random_cmd(logic [3:0] op);
        cmd_t  c;
        word_t w;
        w          = rand_word();
        c.exec     = 1'b1;
        c.rf_we    = w[0];
        c.rs0_sel  = w[1];
        c.rs1_sel  = w[2];
        c.rs2_sel  = w[3];
        c.rf_addr  = w[6:4];
        c.rd       = w[9:7];
        c.opcode   = alu_op_e'(op);
        c.rf_wdata = rand_word();
        c.rs0      = rand_word();
        c.rs1      = rand_word();
        c.rs2      = rand_word();
        return c;
    endfunction

    // commands retire in issue order and read operands before their own rf load
    task automatic apply_command();
        word_t a;
        word_t b;
        word_t c;
        a = staged.rs0_sel ? rf_model[staged.rs0[2:0]] : staged.rs0;
        b = staged.rs1_sel ? rf_model[staged.rs1[2:0]] : staged.rs1;
        c = staged.rs2_sel ? rf_model[staged.rs2[2:0]] : staged.rs2;
        if (staged.rf_we)
            rf_model[staged.rf_addr] = staged.rf_wdata;
        if (staged.exec)
        begin
            result_model        = expected_alu(staged.opcode, a, b, c);
            rf_model[staged.rd] = result_model;  // overrides the rf load
            result_ready        = cyc + 4;
        end
    endtask

    task automatic check_responses();
        exp_rd_t head;
        assert (bus_resp.ack == bus_req.req)
        else
        begin
            errors++;
            $display("ack does not follow req in cycle %0d", cyc);
        end
        assert (led == led_model)
        else
        begin
            errors++;
            $display("[FAIL] led_o: got %h, expected %h", led, led_model);
        end
        if (bus_resp.resp)
        begin
            assert (exp_q.size() > 0)
            else
            begin
                errors++;
                $display("response in cycle %0d with no read outstanding", cyc);
            end
            if (exp_q.size() > 0)
            begin
                head = exp_q.pop_front();
                checks++;
                assert (head.due == cyc)
                else
                begin
                    errors++;
                    $display("read of %h answered in cycle %0d, due in cycle %0d",
                             head.addr, cyc, head.due);
                end
                assert (bus_resp.rdata == head.data)
                else
                begin
                    errors++;
                    $display("[FAIL] bus_resp_o.rdata: got %h, expected %h (addr %h)",
                             bus_resp.rdata, head.data, head.addr);
                end
            end
        end
        else if (exp_q.size() > 0)
        begin
            assert (exp_q[0].due > cyc)
            else
            begin
                errors++;
                $display("no response to read of %h due in cycle %0d",
                         exp_q[0].addr, exp_q[0].due);
                head = exp_q.pop_front();
            end
        end
    endtask

    task automatic next_slot();
        @(negedge clk_gen);
        check_responses();
    endtask

    task automatic drive_bus(logic req, logic we, bus_addr_t addr, byte_en_t be, word_t wdata);
        bus_req.req   = req;
        bus_req.we    = we;
        bus_req.addr  = addr;
        bus_req.be    = be;
        bus_req.wdata = wdata;
    endtask

    task automatic bus_write(bus_addr_t addr, word_t data, byte_en_t be);
        word_t w;
        next_slot();
        drive_bus(1'b1, 1'b1, addr, be, data);
        case (addr)
            `COPRO_LED_ADDR:      led_model = data;
            `COPRO_CTRL_ADDR:
            begin
                staged.rs0_sel = data[1];
                staged.rs1_sel = data[2];
                staged.rs2_sel = data[3];
                if (data[0])
                    apply_command();
            end
            `COPRO_EXEC_ADDR:     staged.exec     = data[0];
            `COPRO_RF_WE_ADDR:    staged.rf_we    = data[0];
            `COPRO_RF_ADDR_ADDR:  staged.rf_addr  = data[2:0];
            `COPRO_RF_WDATA_ADDR: staged.rf_wdata = data;
            `COPRO_OPCODE_ADDR:   staged.opcode   = alu_op_e'(data[3:0]);
            `COPRO_RS0_ADDR:      staged.rs0      = data;
            `COPRO_RS1_ADDR:      staged.rs1      = data;
            `COPRO_RS2_ADDR:      staged.rs2      = data;
            `COPRO_RD_ADDR:       staged.rd       = data[2:0];
            default:
            begin
                if (in_mem_window(addr))
                begin
                    w = mem_model.exists(word_index(addr)) ? mem_model[word_index(addr)] : '0;
                    for (int i = 0; i < 4; i++)
                        if (be[i])
                            w[8*i +: 8] = data[8*i +: 8];
                    mem_model[word_index(addr)] = w;
                end
            end
        endcase
    endtask

    // holds off while the response slot is taken or the result is not yet back
    task automatic bus_read(bus_addr_t addr);
        exp_rd_t ent;
        int      lat;
        lat = in_mem_window(addr) ? 2 : 1;
        next_slot();
        while ((cyc + lat <= last_due) || (addr == `COPRO_RESULT_ADDR && cyc < result_ready))
        begin
            drive_bus(1'b0, 1'b0, '0, '0, '0);
            next_slot();
        end
        ent.addr = addr;
        ent.due  = cyc + lat;
        if (in_mem_window(addr))
            ent.data = mem_model[word_index(addr)];
        else if (addr == `COPRO_LED_ADDR)
            ent.data = led_model;
        else if (addr == `COPRO_SW_ADDR)
        begin
            sw       = rand_word();
            ent.data = sw;
        end
        else
            ent.data = result_model;
        exp_q.push_back(ent);
        last_due = ent.due;
        drive_bus(1'b1, 1'b0, addr, 4'hF, '0);
    endtask

    task automatic load_fields(cmd_t c);
        bus_write(`COPRO_EXEC_ADDR, word_t'(c.exec), 4'hF);
        bus_write(`COPRO_RF_WE_ADDR, word_t'(c.rf_we), 4'hF);
        bus_write(`COPRO_RF_ADDR_ADDR, word_t'(c.rf_addr), 4'hF);
        bus_write(`COPRO_RF_WDATA_ADDR, c.rf_wdata, 4'hF);
        bus_write(`COPRO_OPCODE_ADDR, word_t'(c.opcode), 4'hF);
        bus_write(`COPRO_RS0_ADDR, c.rs0, 4'hF);
        bus_write(`COPRO_RS1_ADDR, c.rs1, 4'hF);
        bus_write(`COPRO_RS2_ADDR, c.rs2, 4'hF);
        bus_write(`COPRO_RD_ADDR, word_t'(c.rd), 4'hF);
    endtask

    task automatic launch(cmd_t c);
        bus_write(`COPRO_CTRL_ADDR, {28'd0, c.rs2_sel, c.rs1_sel, c.rs0_sel, 1'b1}, 4'hF);
    endtask

    initial
    begin
        cmd_t     c;
        word_t    w;
        rf_addr_t r;
        bus_req      = '0;
        sw           = '0;
        rst_n_i      = 1'b0;
        led_model    = '0;
        result_model = '0;
        staged       = '0;
        for (int i = 0; i < `COPRO_RF_DEPTH; i++)
            rf_model[i] = '0;
        repeat (10) @(posedge clk_gen);
        @(negedge clk_gen);
        rst_n_i = 1'b1;

        for (int i = 0; i < LED_ITERS; i++)
        begin
            bus_write(`COPRO_LED_ADDR, rand_word(), 4'hF);
            bus_read(`COPRO_LED_ADDR);
            bus_read(`COPRO_SW_ADDR);
        end

        // full words first so no byte of a pool word is unknown
        for (int i = 0; i < MEM_POOL; i++)
        begin
            w       = rand_word();
            pool[i] = int'(w[`COPRO_MEM_AWIDTH-1:0]);
            bus_write(`COPRO_MEM_BASE + bus_addr_t'(pool[i] * 4), rand_word(), 4'hF);
        end
        for (int i = 0; i < MEM_WRITES; i++)
        begin
            w = rand_word();
            bus_write(pool_addr(), rand_word(), w[3:0]);
        end
        for (int i = 0; i < MEM_READS; i++)
            bus_read(pool_addr());

        for (int i = 0; i < `COPRO_RF_DEPTH; i++)
        begin
            c         = random_cmd(4'd0);
            c.exec    = 1'b0;
            c.rf_we   = 1'b1;
            c.rf_addr = rf_addr_t'(i);
            load_fields(c);
            launch(c);
        end
        for (int i = 0; i < EXEC_CMDS; i++)
        begin
            c = random_cmd(4'(i % 10));  // code 9 is unknown
            load_fields(c);
            launch(c);
            bus_read(`COPRO_RESULT_ADDR);
        end

        // launches on consecutive cycles that each read the previous rd
        for (int i = 0; i < CHAIN_ROUNDS; i++)
        begin
            c         = random_cmd(CHAIN_OPS[i]);
            c.rf_we   = 1'b0;
            c.rs0_sel = 1'b1;
            c.rs1_sel = 1'b0;
            c.rs2_sel = 1'b1;
            c.rs0     = word_t'(c.rd);
            c.rs2     = word_t'(c.rd);
            load_fields(c);
            repeat (CHAIN_LEN) launch(c);
            bus_read(`COPRO_RESULT_ADDR);
        end

        // rf load and execute into one register then read back with OR 0
        for (int i = 0; i < COMBO_ROUNDS; i++)
        begin
            c         = random_cmd(4'(i * 2));
            c.rf_we   = 1'b1;
            c.rf_addr = c.rd;
            r         = c.rd;
            load_fields(c);
            launch(c);
            c         = random_cmd(4'd3);
            c.rf_we   = 1'b0;
            c.rs0_sel = 1'b1;
            c.rs0     = word_t'(r);
            c.rs1_sel = 1'b0;
            c.rs1     = '0;
            load_fields(c);
            launch(c);
            bus_read(`COPRO_RESULT_ADDR);
        end

        for (int i = 0; i < MIX_READS; i++)
        begin
            w = rand_word();
            case (w[1:0])
                2'd0:    bus_read(`COPRO_LED_ADDR);
                2'd1:    bus_read(`COPRO_SW_ADDR);
                2'd2:    bus_read(`COPRO_RESULT_ADDR);
                default: bus_read(pool_addr());
            endcase
        end

        while (exp_q.size() > 0)
        begin
            next_slot();
            drive_bus(1'b0, 1'b0, '0, '0, '0);
        end
        repeat (3) next_slot();  // stray responses

        $display("reads checked: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+include
design/copro_pkg.sv
design/bus_csr.sv
design/test_mem.sv
design/copro_alu.sv
design/copro_engine.sv
design/copro_top.sv
bench/tb_copro.sv

/* design/bus_csr.sv */
`timescale 1ns/1ps
`default_nettype none

`include "copro_params.svh"

module bus_csr
    import copro_pkg::*;
(
    input  wire logic      clk_gen,
    input  wire logic      rst_n_i,
    input  wire bus_req_t  bus_req_i,
    output bus_resp_t      bus_resp_o,
    input  wire word_t     sw_i,
    output word_t          led_o,
    output logic           mem_we_o,
    output mem_addr_t      mem_addr_o,
    output byte_en_t       mem_be_o,
    output word_t          mem_wdata_o,
    input  wire word_t     mem_rdata_i,
    output logic           cmd_valid_o,
    output cmd_t           cmd_o,
    input  wire logic      res_valid_i,
    input  wire word_t     res_data_i
);

    localparam bus_addr_t MEM_LIMIT = `COPRO_MEM_BASE + bus_addr_t'(`COPRO_MEM_WORDS * 4);

    logic  wr_en;
    logic  rd_en;
    logic  mem_hit;
    logic  reg_rd_hit;
    word_t reg_rdata_d;

    word_t result_q;
    word_t reg_rdata_q;
    logic  reg_resp_q;     // register read, 1 cycle
    logic  mem_resp_d1_q;  // memory read, first stage
    logic  mem_resp_q;

    always_comb
    begin
        wr_en   = bus_req_i.req & bus_req_i.we;
        rd_en   = bus_req_i.req & ~bus_req_i.we;
        mem_hit = (bus_req_i.addr >= `COPRO_MEM_BASE) && (bus_req_i.addr < MEM_LIMIT);

        reg_rd_hit  = 1'b0;
        reg_rdata_d = '0;
        case (bus_req_i.addr)
            `COPRO_LED_ADDR:
            begin
                reg_rd_hit  = rd_en;
                reg_rdata_d = led_o;
            end
            `COPRO_SW_ADDR:
            begin
                reg_rd_hit  = rd_en;
                reg_rdata_d = sw_i;
            end
            `COPRO_RESULT_ADDR:
            begin
                reg_rd_hit  = rd_en;
                reg_rdata_d = result_q;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_gen or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            led_o         <= '0;
            result_q      <= '0;
            cmd_valid_o   <= 1'b0;
            mem_we_o      <= 1'b0;
            reg_resp_q    <= 1'b0;
            mem_resp_d1_q <= 1'b0;
            mem_resp_q    <= 1'b0;
        end
        else
        begin
            if (wr_en && (bus_req_i.addr == `COPRO_LED_ADDR))
                led_o <= bus_req_i.wdata;
            if (res_valid_i)
                result_q <= res_data_i;
            cmd_valid_o   <= wr_en && (bus_req_i.addr == `COPRO_CTRL_ADDR) && bus_req_i.wdata[0];
            mem_we_o      <= wr_en && mem_hit;
            reg_resp_q    <= reg_rd_hit;
            mem_resp_d1_q <= rd_en && mem_hit;
            mem_resp_q    <= mem_resp_d1_q;  // lines up with registered ram output
        end
    end

    always_ff @(posedge clk_gen)
    begin
        if (bus_req_i.req && mem_hit)
        begin
            mem_addr_o  <= bus_req_i.addr[`COPRO_MEM_AWIDTH+1:2];  // word aligned
            mem_be_o    <= bus_req_i.be;
            mem_wdata_o <= bus_req_i.wdata;
        end

        if (reg_rd_hit)
            reg_rdata_q <= reg_rdata_d;

        if (wr_en)
        begin
            case (bus_req_i.addr)
                `COPRO_CTRL_ADDR:
                begin
                    cmd_o.rs0_sel <= bus_req_i.wdata[1];
                    cmd_o.rs1_sel <= bus_req_i.wdata[2];
                    cmd_o.rs2_sel <= bus_req_i.wdata[3];
                end
                `COPRO_EXEC_ADDR:     cmd_o.exec     <= bus_req_i.wdata[0];
                `COPRO_RF_WE_ADDR:    cmd_o.rf_we    <= bus_req_i.wdata[0];
                `COPRO_RF_ADDR_ADDR:  cmd_o.rf_addr  <= bus_req_i.wdata[`COPRO_RF_AWIDTH-1:0];
                `COPRO_RF_WDATA_ADDR: cmd_o.rf_wdata <= bus_req_i.wdata;
                `COPRO_OPCODE_ADDR:   cmd_o.opcode   <= alu_op_e'(bus_req_i.wdata[3:0]);
                `COPRO_RS0_ADDR:      cmd_o.rs0      <= bus_req_i.wdata;
                `COPRO_RS1_ADDR:      cmd_o.rs1      <= bus_req_i.wdata;
                `COPRO_RS2_ADDR:      cmd_o.rs2      <= bus_req_i.wdata;
                `COPRO_RD_ADDR:       cmd_o.rd       <= bus_req_i.wdata[`COPRO_RF_AWIDTH-1:0];
                default: ;
            endcase
        end
    end

    // memory data has priority if both land in one cycle
    always_comb
    begin
        bus_resp_o.ack  = bus_req_i.req;
        bus_resp_o.resp = reg_resp_q | mem_resp_q;
        if (mem_resp_q)
            bus_resp_o.rdata = mem_rdata_i;
        else if (reg_resp_q)
            bus_resp_o.rdata = reg_rdata_q;
        else
            bus_resp_o.rdata = '0;
    end

endmodule

`default_nettype wire

/* design/copro_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module copro_alu
    import copro_pkg::*;
(
    input  wire alu_op_e op_i,
    input  wire word_t   a_i,
    input  wire word_t   b_i,
    input  wire word_t   c_i,
    output word_t        y_o
);

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb
    begin
        case (op_i)
            ALU_ADD:    y_o = a_i + b_i;
            ALU_SUB:    y_o = a_i - b_i;
            ALU_AND:    y_o = a_i & b_i;
            ALU_OR:     y_o = a_i | b_i;
            ALU_XOR:    y_o = a_i ^ b_i;
            ALU_SLL:    y_o = a_i << shamt;
            ALU_SRL:    y_o = a_i >> shamt;
            ALU_MUL:    y_o = a_i * b_i;        // low word only
            ALU_MULADD: y_o = a_i * b_i + c_i;
            default:    y_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/copro_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "copro_params.svh"

module copro_engine
    import copro_pkg::*;
(
    input  wire logic clk_gen,
    input  wire logic rst_n_i,
    input  wire logic cmd_valid_i,
    input  wire cmd_t cmd_i,
    output logic      res_valid_o,
    output word_t     res_data_o
);

    word_t    rf_q [`COPRO_RF_DEPTH];

    logic [2:0] opnd_sel;
    word_t    opnd_imm [3];
    rf_addr_t rf_idx [3];
    word_t    opnd_d [3];

    // execute stage
    logic     s2_exec_q;
    alu_op_e  s2_op_q;
    rf_addr_t s2_rd_q;
    word_t    s2_opnd_q [3];
    word_t    alu_y;

    // operand fetch, bypassing the result still in execute
    always_comb
    begin
        opnd_sel    = {cmd_i.rs2_sel, cmd_i.rs1_sel, cmd_i.rs0_sel};
        opnd_imm[0] = cmd_i.rs0;
        opnd_imm[1] = cmd_i.rs1;
        opnd_imm[2] = cmd_i.rs2;
        for (int i = 0; i < 3; i++)
        begin
            rf_idx[i] = opnd_imm[i][`COPRO_RF_AWIDTH-1:0];
            if (!opnd_sel[i])
                opnd_d[i] = opnd_imm[i];
            else if (s2_exec_q && (s2_rd_q == rf_idx[i]))
                opnd_d[i] = alu_y;
            else
                opnd_d[i] = rf_q[rf_idx[i]];
        end
    end

    copro_alu copro_alu_inst (
        .op_i (s2_op_q),
        .a_i  (s2_opnd_q[0]),
        .b_i  (s2_opnd_q[1]),
        .c_i  (s2_opnd_q[2]),
        .y_o  (alu_y)
    );

    always_ff @(posedge clk_gen or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            s2_exec_q   <= 1'b0;
            res_valid_o <= 1'b0;
            for (int i = 0; i < `COPRO_RF_DEPTH; i++)
                rf_q[i] <= '0;
        end
        else
        begin
            s2_exec_q   <= cmd_valid_i & cmd_i.exec;
            res_valid_o <= s2_exec_q;
            if (s2_exec_q)
                rf_q[s2_rd_q] <= alu_y;
            // younger command's rf write lands last
            if (cmd_valid_i && cmd_i.rf_we)
                rf_q[cmd_i.rf_addr] <= cmd_i.rf_wdata;
        end
    end

    always_ff @(posedge clk_gen)
    begin
        if (cmd_valid_i)
        begin
            s2_op_q <= cmd_i.opcode;
            s2_rd_q <= cmd_i.rd;
            for (int i = 0; i < 3; i++)
                s2_opnd_q[i] <= opnd_d[i];
        end
        if (s2_exec_q)
            res_data_o <= alu_y;
    end

endmodule

`default_nettype wire

/* design/copro_pkg.sv */
`default_nettype none

`include "copro_params.svh"

package copro_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] bus_addr_t;  // byte address
    typedef logic [3:0]  byte_en_t;
    typedef logic [`COPRO_RF_AWIDTH-1:0]  rf_addr_t;
    typedef logic [`COPRO_MEM_AWIDTH-1:0] mem_addr_t;  // word index

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLL    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_MUL    = 4'd7,
        ALU_MULADD = 4'd8
    } alu_op_e;

    typedef struct packed {
        logic      req;
        logic      we;
        bus_addr_t addr;
        byte_en_t  be;
        word_t     wdata;
    } bus_req_t;

    typedef struct packed {
        logic  ack;
        logic  resp;
        word_t rdata;
    } bus_resp_t;

    // operand select: 1 = register file, 0 = immediate
    typedef struct packed {
        logic     exec;
        logic     rf_we;
        rf_addr_t rf_addr;
        word_t    rf_wdata;
        alu_op_e  opcode;
        logic     rs0_sel;
        logic     rs1_sel;
        logic     rs2_sel;
        word_t    rs0;
        word_t    rs1;
        word_t    rs2;
        rf_addr_t rd;
    } cmd_t;

endpackage

`default_nettype wire

/* design/copro_top.sv */
`timescale 1ns/1ps
`default_nettype none

module copro_top
    import copro_pkg::*;
(
    input  wire logic     clk_gen,
    input  wire logic     rst_n_i,
    input  wire bus_req_t bus_req_i,
    output bus_resp_t     bus_resp_o,
    input  wire word_t    sw_i,
    output word_t         led_o
);

    logic      mem_we;
    mem_addr_t mem_addr;
    byte_en_t  mem_be;
    word_t     mem_wdata;
    word_t     mem_rdata;

    logic      cmd_valid;
    cmd_t      cmd;
    logic      res_valid;
    word_t     res_data;

    bus_csr bus_csr_inst (
        .clk_gen     (clk_gen),
        .rst_n_i     (rst_n_i),
        .bus_req_i   (bus_req_i),
        .bus_resp_o  (bus_resp_o),
        .sw_i        (sw_i),
        .led_o       (led_o),
        .mem_we_o    (mem_we),
        .mem_addr_o  (mem_addr),
        .mem_be_o    (mem_be),
        .mem_wdata_o (mem_wdata),
        .mem_rdata_i (mem_rdata),
        .cmd_valid_o (cmd_valid),
        .cmd_o       (cmd),
        .res_valid_i (res_valid),
        .res_data_i  (res_data)
    );

    test_mem test_mem_inst (
        .clk_gen (clk_gen),
        .we_i    (mem_we),
        .addr_i  (mem_addr),
        .be_i    (mem_be),
        .wdata_i (mem_wdata),
        .rdata_o (mem_rdata)
    );

    copro_engine copro_engine_inst (
        .clk_gen     (clk_gen),
        .rst_n_i     (rst_n_i),
        .cmd_valid_i (cmd_valid),
        .cmd_i       (cmd),
        .res_valid_o (res_valid),
        .res_data_o  (res_data)
    );

endmodule

`default_nettype wire

/* design/test_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "copro_params.svh"

module test_mem
    import copro_pkg::*;
(
    input  wire logic      clk_gen,
    input  wire logic      we_i,
    input  wire mem_addr_t addr_i,
    input  wire byte_en_t  be_i,
    input  wire word_t     wdata_i,
    output word_t          rdata_o
);

    word_t mem_q [`COPRO_MEM_WORDS];

    always_ff @(posedge clk_gen)
    begin
        if (we_i)
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (be_i[i])
                    mem_q[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
            end
        end
        rdata_o <= mem_q[addr_i];  // old data on same-address write
    end

endmodule

`default_nettype wire

/* include/copro_params.svh */
`ifndef COPRO_PARAMS_SVH
`define COPRO_PARAMS_SVH

// board registers
`define COPRO_LED_ADDR      32'h0000_0000
`define COPRO_SW_ADDR       32'h0000_0004

// test memory window
`define COPRO_MEM_BASE      32'h8000_0000
`define COPRO_MEM_AWIDTH    10
`define COPRO_MEM_WORDS     (1 << `COPRO_MEM_AWIDTH)

// command staging registers, 0x1000_0014 reserved
`define COPRO_CTRL_ADDR     32'h1000_0000
`define COPRO_EXEC_ADDR     32'h1000_0004
`define COPRO_RF_WE_ADDR    32'h1000_0008
`define COPRO_RF_ADDR_ADDR  32'h1000_000C
`define COPRO_RF_WDATA_ADDR 32'h1000_0010
`define COPRO_OPCODE_ADDR   32'h1000_0018
`define COPRO_RS0_ADDR      32'h1000_001C
`define COPRO_RS1_ADDR      32'h1000_0020
`define COPRO_RS2_ADDR      32'h1000_0024
`define COPRO_RD_ADDR       32'h1000_0028

`define COPRO_RESULT_ADDR   32'h1000_0040

// register file
`define COPRO_RF_AWIDTH     3
`define COPRO_RF_DEPTH      (1 << `COPRO_RF_AWIDTH)

`endif

/* run_sim.sh */
#!/bin/sh
# compile and run tb_copro with Verilator, then scan the log for the fail message
verilator --binary --timing --assert -f build.f --top-module tb_copro \
    -Mdir obj_dir -o tb_copro > build.log 2>&1 \
    && ./obj_dir/tb_copro > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Finished with errors" sim.log && exit 1 || exit 0
